/* cpu_defs.svh */
/* widths, encodings and memory sizes shared by RTL and testbench
   both memories are 64 words, indexed by byte address bits [7:2] */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_XLEN       32
`define CPU_REG_BITS   5
`define CPU_MEM_WORDS  64
`define CPU_MEM_ABITS  6
`define CPU_RESET_PC   32'h0000_0000

// major opcodes
`define CPU_OP_RTYPE   7'b0110011
`define CPU_OP_ITYPE   7'b0010011
`define CPU_OP_LOAD    7'b0000011
`define CPU_OP_STORE   7'b0100011
`define CPU_OP_BRANCH  7'b1100011
`define CPU_OP_SYSTEM  7'b1110011

`define CPU_F3_ADD     3'b000  // add, sub, addi
`define CPU_F3_OR      3'b110
`define CPU_F3_AND     3'b111
`define CPU_F3_WORD    3'b010  // lw, sw
`define CPU_F3_BEQ     3'b000
`define CPU_F3_BNE     3'b001
`define CPU_F7_SUB     7'b0100000

`define CPU_HALT_REG   5'd17   // a7
`define CPU_HALT_CODE  32'd10

`endif

/* cpu_pkg.sv */
/* types shared by the pipeline stages
   an all-zero ctrl_t is a no-op */
`include "cpu_defs.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_or  = 2'd3
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_reg = 2'd0,  // value read in decode
        fwd_mem = 2'd1,  // EX/MEM alu result
        fwd_wb  = 2'd2   // MEM/WB writeback data
    } fwd_sel_t;

    typedef struct packed {
        logic    alu_src;    // second alu operand is the immediate
        alu_op_t alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch;
        logic    branch_ne;  // bne when set
        logic    is_ecall;
    } ctrl_t;

endpackage

/* fwd_if.sv */
/* destination results of EX/MEM and MEM/WB
   mem_data is always the alu result since loads never forward from EX/MEM */
`timescale 1ns/10ps

interface fwd_if;
    logic              mem_reg_write;
    cpu_pkg::reg_idx_t mem_rd;
    cpu_pkg::word_t    mem_data;
    logic              wb_reg_write;  // also the register file write port
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    modport source (
        output mem_reg_write, mem_rd, mem_data,
        output wb_reg_write, wb_rd, wb_data
    );

    modport sink (
        input mem_reg_write, mem_rd, mem_data,
        input wb_reg_write, wb_rd, wb_data
    );
endinterface

/* register_file.sv */
/* x0 always reads zero
   a write is visible to reads in the same cycle */
`timescale 1ns/10ps

module register_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::word_t    rd_data,
    input  logic              write,
    input  cpu_pkg::reg_idx_t dbg_addr,
    output cpu_pkg::word_t    rs1_data,
    output cpu_pkg::word_t    rs2_data,
    output cpu_pkg::word_t    dbg_data
);
    cpu_pkg::word_t regs [32];
    logic           wr_en;

    assign wr_en = write && (rd != '0);  // writes to x0 dropped

    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_idx_t addr);
        if (wr_en && addr == rd) begin
            return rd_data;  // write-through
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
        dbg_data = read_port(dbg_addr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= rd_data;
        end
    end
endmodule

/* fetch_stage.sv */
/* imem is written through the load port while reset is held
   pc bits above the memory depth are ignored so fetch wraps */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module fetch_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      flush,
    input  cpu_pkg::word_t            branch_target,
    input  logic                      imem_we,
    input  logic [`CPU_MEM_ABITS-1:0] imem_addr,
    input  cpu_pkg::word_t            imem_data,
    output cpu_pkg::word_t            if_inst,
    output cpu_pkg::word_t            if_pc
);
    cpu_pkg::word_t imem [`CPU_MEM_WORDS];
    cpu_pkg::word_t pc;
    cpu_pkg::word_t fetch_word;

    assign fetch_word = imem[pc[`CPU_MEM_ABITS+1:2]];  // async read

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (flush) begin
            pc <= branch_target;  // redirect beats stall
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // zero word in IF/ID decodes as a no-op
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            if_inst <= '0;
            if_pc   <= '0;
        end else if (!stall) begin
            if_inst <= fetch_word;
            if_pc   <= pc;
        end
    end
endmodule

/* decode_stage.sv */
/* unsupported opcodes and funct codes decode to a no-op control word
   a load-use hazard holds IF/ID for one cycle and sends a bubble to execute */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::word_t    if_inst,
    input  cpu_pkg::word_t    if_pc,
    input  logic              flush,
    fwd_if.sink               fwd,
    input  cpu_pkg::reg_idx_t dbg_reg_addr,
    output logic              stall,
    output cpu_pkg::word_t    dbg_reg_data,
    output cpu_pkg::ctrl_t    ex_ctrl,
    output cpu_pkg::word_t    ex_rs1_data,
    output cpu_pkg::word_t    ex_rs2_data,
    output cpu_pkg::word_t    ex_imm,
    output cpu_pkg::word_t    ex_pc,
    output cpu_pkg::reg_idx_t ex_rs1,
    output cpu_pkg::reg_idx_t ex_rs2,
    output cpu_pkg::reg_idx_t ex_rd
);
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    cpu_pkg::reg_idx_t rs1;
    cpu_pkg::reg_idx_t rs2;
    cpu_pkg::word_t    rs1_data;
    cpu_pkg::word_t    rs2_data;
    cpu_pkg::word_t    imm;
    cpu_pkg::ctrl_t    ctrl;

    assign opcode = if_inst[6:0];
    assign funct3 = if_inst[14:12];
    assign funct7 = if_inst[31:25];
    assign rs2    = if_inst[24:20];

    always_comb begin
        ctrl = '0;
        imm  = {{20{if_inst[31]}}, if_inst[31:20]};  // I format
        rs1  = if_inst[19:15];
        case (opcode)
            `CPU_OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0, `CPU_F3_ADD}:        ctrl.alu_op = cpu_pkg::alu_add;
                    {`CPU_F7_SUB, `CPU_F3_ADD}: ctrl.alu_op = cpu_pkg::alu_sub;
                    {7'b0, `CPU_F3_AND}:        ctrl.alu_op = cpu_pkg::alu_and;
                    {7'b0, `CPU_F3_OR}:         ctrl.alu_op = cpu_pkg::alu_or;
                    default:                    ctrl.reg_write = 1'b0;
                endcase
            end
            `CPU_OP_ITYPE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = (funct3 == `CPU_F3_ADD);  // addi only
            end
            `CPU_OP_LOAD: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = (funct3 == `CPU_F3_WORD);
                ctrl.reg_write = (funct3 == `CPU_F3_WORD);
            end
            `CPU_OP_STORE: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = (funct3 == `CPU_F3_WORD);
                imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            end
            `CPU_OP_BRANCH: begin
                ctrl.branch    = (funct3 == `CPU_F3_BEQ) || (funct3 == `CPU_F3_BNE);
                ctrl.branch_ne = (funct3 == `CPU_F3_BNE);
                imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7],
                       if_inst[30:25], if_inst[11:8], 1'b0};
            end
            `CPU_OP_SYSTEM: begin
                ctrl.is_ecall = (if_inst[31:7] == '0);
                rs1 = `CPU_HALT_REG;  // ecall checks a7
            end
            default: ;
        endcase
    end

    // load in ID/EX feeding either source of this instruction
    assign stall = ex_ctrl.mem_read && (ex_rd != '0) && (ex_rd == rs1 || ex_rd == rs2);

    register_file u_regs (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (fwd.wb_rd),
        .rd_data  (fwd.wb_data),
        .write    (fwd.wb_reg_write),
        .dbg_addr (dbg_reg_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_reg_data)
    );

    always_ff @(posedge clk) begin
        if (reset || flush || stall) begin
            ex_ctrl <= '0;  // bubble
        end else begin
            ex_ctrl <= ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1_data <= rs1_data;
        ex_rs2_data <= rs2_data;
        ex_imm      <= imm;
        ex_pc       <= if_pc;
        ex_rs1      <= rs1;
        ex_rs2      <= rs2;
        ex_rd       <= if_inst[11:7];
    end
endmodule

/* execute_stage.sv */
/* forwarding prefers EX/MEM over MEM/WB and never forwards x0
   a taken branch raises flush combinationally while it sits in ID/EX */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::ctrl_t    ex_ctrl,
    input  cpu_pkg::word_t    ex_rs1_data,
    input  cpu_pkg::word_t    ex_rs2_data,
    input  cpu_pkg::word_t    ex_imm,
    input  cpu_pkg::word_t    ex_pc,
    input  cpu_pkg::reg_idx_t ex_rs1,
    input  cpu_pkg::reg_idx_t ex_rs2,
    input  cpu_pkg::reg_idx_t ex_rd,
    fwd_if.sink               fwd,
    output logic              flush,
    output cpu_pkg::word_t    branch_target,
    output cpu_pkg::ctrl_t    mem_ctrl,
    output cpu_pkg::word_t    mem_alu,
    output cpu_pkg::word_t    mem_store,
    output cpu_pkg::reg_idx_t mem_rd,
    output logic              mem_halt
);
    cpu_pkg::fwd_sel_t sel_a;
    cpu_pkg::fwd_sel_t sel_b;
    cpu_pkg::word_t    op_a;
    cpu_pkg::word_t    op_b;
    cpu_pkg::word_t    alu_b;
    cpu_pkg::word_t    alu_out;
    logic              halt;

    function automatic cpu_pkg::fwd_sel_t pick(input cpu_pkg::reg_idx_t rs);
        if (rs == '0) begin
            return cpu_pkg::fwd_reg;
        end else if (fwd.mem_reg_write && fwd.mem_rd == rs) begin
            return cpu_pkg::fwd_mem;  // youngest result first
        end else if (fwd.wb_reg_write && fwd.wb_rd == rs) begin
            return cpu_pkg::fwd_wb;
        end
        return cpu_pkg::fwd_reg;
    endfunction

    function automatic cpu_pkg::word_t operand(input cpu_pkg::fwd_sel_t sel,
                                               input cpu_pkg::word_t reg_val);
        case (sel)
            cpu_pkg::fwd_mem: return fwd.mem_data;
            cpu_pkg::fwd_wb:  return fwd.wb_data;
            default:          return reg_val;
        endcase
    endfunction

    always_comb begin
        sel_a = pick(ex_rs1);
        sel_b = pick(ex_rs2);
        op_a  = operand(sel_a, ex_rs1_data);
        op_b  = operand(sel_b, ex_rs2_data);
        alu_b = ex_ctrl.alu_src ? ex_imm : op_b;
        case (ex_ctrl.alu_op)
            cpu_pkg::alu_sub: alu_out = op_a - alu_b;
            cpu_pkg::alu_and: alu_out = op_a & alu_b;
            cpu_pkg::alu_or:  alu_out = op_a | alu_b;
            default:          alu_out = op_a + alu_b;
        endcase
    end

    assign flush         = ex_ctrl.branch && ((op_a == op_b) != ex_ctrl.branch_ne);
    assign branch_target = ex_pc + ex_imm;
    assign halt          = ex_ctrl.is_ecall && (op_a == `CPU_HALT_CODE);  // op_a is a7 here

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_ctrl <= '0;
            mem_halt <= 1'b0;
        end else begin
            mem_ctrl <= ex_ctrl;
            mem_halt <= halt;
        end
    end

    always_ff @(posedge clk) begin
        mem_alu   <= alu_out;
        mem_store <= op_b;  // forwarded sw data
        mem_rd    <= ex_rd;
    end
endmodule

/* memory_stage.sv */
/* dmem reads combinationally and writes at the edge, word addressed by alu[7:2]
   is_halted stays high from the halting ecall's writeback until reset */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module memory_stage (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::ctrl_t    mem_ctrl,
    input  cpu_pkg::word_t    mem_alu,
    input  cpu_pkg::word_t    mem_store,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  logic              mem_halt,
    fwd_if.source             fwd,
    output logic              is_halted
);
    cpu_pkg::word_t            dmem [`CPU_MEM_WORDS];
    logic [`CPU_MEM_ABITS-1:0] dmem_addr;
    cpu_pkg::word_t            load_data;
    logic                      wb_reg_write;
    logic                      wb_load;
    cpu_pkg::reg_idx_t         wb_rd;
    cpu_pkg::word_t            wb_alu;
    cpu_pkg::word_t            wb_load_data;

    assign dmem_addr = mem_alu[`CPU_MEM_ABITS+1:2];
    assign load_data = dmem[dmem_addr];

    always_ff @(posedge clk) begin
        if (mem_ctrl.mem_write) begin
            dmem[dmem_addr] <= mem_store;
        end
    end

    // EX/MEM forwarding source
    assign fwd.mem_reg_write = mem_ctrl.reg_write;
    assign fwd.mem_rd        = mem_rd;
    assign fwd.mem_data      = mem_alu;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_reg_write <= 1'b0;
            is_halted    <= 1'b0;
        end else begin
            wb_reg_write <= mem_ctrl.reg_write;
            is_halted    <= is_halted | mem_halt;  // sticky
        end
    end

    always_ff @(posedge clk) begin
        wb_load      <= mem_ctrl.mem_read;
        wb_rd        <= mem_rd;
        wb_alu       <= mem_alu;
        wb_load_data <= load_data;
    end

    assign fwd.wb_reg_write = wb_reg_write;
    assign fwd.wb_rd        = wb_rd;
    assign fwd.wb_data      = wb_load ? wb_load_data : wb_alu;
endmodule

/* cpu.sv */
/* five-stage core for add, sub, and, or, addi, lw, sw, beq, bne and ecall
   load imem while reset is high; is_halted marks the end of a program */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      imem_we,
    input  logic [`CPU_MEM_ABITS-1:0] imem_addr,
    input  cpu_pkg::word_t            imem_data,
    input  cpu_pkg::reg_idx_t         dbg_reg_addr,
    output logic                      is_halted,
    output cpu_pkg::word_t            dbg_reg_data
);
    cpu_pkg::word_t    if_inst;
    cpu_pkg::word_t    if_pc;
    logic              stall;
    logic              flush;
    cpu_pkg::word_t    branch_target;
    cpu_pkg::ctrl_t    ex_ctrl;
    cpu_pkg::word_t    ex_rs1_data;
    cpu_pkg::word_t    ex_rs2_data;
    cpu_pkg::word_t    ex_imm;
    cpu_pkg::word_t    ex_pc;
    cpu_pkg::reg_idx_t ex_rs1;
    cpu_pkg::reg_idx_t ex_rs2;
    cpu_pkg::reg_idx_t ex_rd;
    cpu_pkg::ctrl_t    mem_ctrl;
    cpu_pkg::word_t    mem_alu;
    cpu_pkg::word_t    mem_store;
    cpu_pkg::reg_idx_t mem_rd;
    logic              mem_halt;

    fwd_if fwd ();  // EX/MEM and MEM/WB results

    fetch_stage   u_fetch   (.*);
    decode_stage  u_decode  (.*);
    execute_stage u_execute (.*);
    memory_stage  u_memory  (.*);
endmodule

/* clock_gen.sv */
/* free-running 40 ns clock
   reset is high for the first 16 rising edges and drops 2 ns after the last */
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
    end
endmodule

/* cpu_properties.sv */
/* bound to cpu, checks the halt flag and the debug read port
   x0 is only checked once reset has cleared the register file */
`timescale 1ns/10ps

module cpu_properties (
    input logic              clk,
    input logic              reset,
    input logic              is_halted,
    input cpu_pkg::reg_idx_t dbg_reg_addr,
    input cpu_pkg::word_t    dbg_reg_data
);
    // reset always clears the flag
    halt_cleared: assert property (@(posedge clk) reset |=> !is_halted)
        else $error("is_halted still high in the cycle after reset");

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        is_halted |=> is_halted)
        else $error("is_halted dropped without reset");

    x0_reads_zero: assert property (@(posedge clk) disable iff (reset)
        dbg_reg_addr == '0 |-> dbg_reg_data == '0)
        else $error("debug read of x0 returned a nonzero value");
endmodule

/* cpu_tb.sv */
/* directed tests for the cpu; each loads imem under reset and runs to is_halted
   inputs change 2 ns after the rising edge, outputs are sampled on the falling edge */
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_tb;
    localparam logic [31:0] LCG_SEED = 32'hb713_a7e6;
    localparam int NUM_TESTS   = 6;
    localparam int HALT_LIMIT  = 100;  // cycles from reset release
    localparam int WATCHDOG_NS = NUM_TESTS * 300 * 40;

    logic                      clk;
    logic                      por;
    logic                      tb_reset;
    logic                      reset;
    logic                      imem_we;
    logic [`CPU_MEM_ABITS-1:0] imem_addr;
    cpu_pkg::word_t            imem_data;
    cpu_pkg::reg_idx_t         dbg_reg_addr;
    logic                      is_halted;
    cpu_pkg::word_t            dbg_reg_data;

    cpu_pkg::word_t prog[$];
    logic [31:0]    lcg_state;
    int             errors;
    int             tests_failed;

    assign reset = por | tb_reset;

    clock_gen u_clk (.clk(clk), .reset(por));

    cpu UUT (
        .clk          (clk),
        .reset        (reset),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dbg_reg_addr (dbg_reg_addr),
        .is_halted    (is_halted),
        .dbg_reg_data (dbg_reg_data)
    );

    bind cpu cpu_properties u_props (
        .clk          (clk),
        .reset        (reset),
        .is_halted    (is_halted),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    // instruction encoders
    function automatic cpu_pkg::word_t alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                              input cpu_pkg::reg_idx_t rd,
                                              input cpu_pkg::reg_idx_t rs1,
                                              input cpu_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `CPU_OP_RTYPE};
    endfunction

    function automatic cpu_pkg::word_t addi(input cpu_pkg::reg_idx_t rd,
                                            input cpu_pkg::reg_idx_t rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, `CPU_F3_ADD, rd, `CPU_OP_ITYPE};
    endfunction

    function automatic cpu_pkg::word_t load_word(input cpu_pkg::reg_idx_t rd,
                                                 input cpu_pkg::reg_idx_t rs1,
                                                 input logic [11:0] imm);
        return {imm, rs1, `CPU_F3_WORD, rd, `CPU_OP_LOAD};
    endfunction

    function automatic cpu_pkg::word_t store_word(input cpu_pkg::reg_idx_t rs2,
                                                  input cpu_pkg::reg_idx_t rs1,
                                                  input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, `CPU_F3_WORD, imm[4:0], `CPU_OP_STORE};
    endfunction

    function automatic cpu_pkg::word_t branch_if(input logic [2:0] f3,
                                                 input cpu_pkg::reg_idx_t rs1,
                                                 input cpu_pkg::reg_idx_t rs2,
                                                 input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `CPU_OP_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t sext(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [11:0] rand_imm();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[27:16];  // upper bits since the low ones cycle fast
    endfunction

    task automatic append_halt();
        prog.push_back(addi(`CPU_HALT_REG, 5'd0, 12'd10));
        prog.push_back({25'd0, `CPU_OP_SYSTEM});  // ecall
    endtask

    // whole imem rewritten under reset
    // unused words hold addi x0, x0, addr
    task automatic load_program();
        @(posedge clk);
        #2;
        tb_reset = 1'b1;
        for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
            imem_we   = 1'b1;
            imem_addr = i[`CPU_MEM_ABITS-1:0];
            imem_data = (i < prog.size()) ? prog[i] : addi(5'd0, 5'd0, i[11:0]);
            @(posedge clk);
            #2;
        end
        imem_we  = 1'b0;
        tb_reset = 1'b0;
    endtask

    // cycles counts falling edges after release
    // is_halted is first seen at ecall index + 4
    task automatic run_to_halt(output int cycles);
        cycles = -1;
        for (int n = 0; n < HALT_LIMIT; n++) begin
            @(negedge clk);
            if (is_halted === 1'b1) begin
                cycles = n;
                break;
            end
        end
        if (cycles < 0) begin
            $display("ERROR at %0t: program did not halt within %0d cycles", $time, HALT_LIMIT);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_halt(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input cpu_pkg::reg_idx_t r, input cpu_pkg::word_t exp);
        cpu_pkg::word_t val;
        @(posedge clk);
        #2;
        dbg_reg_addr = r;
        @(negedge clk);
        val = dbg_reg_data;
        check_word($sformatf("x%0d", r), val, exp);
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s FAILED with %0d errors", name, errors - start);
        end
    endtask

    // dependencies at distance 1, 2 and 3 hit EX/MEM, MEM/WB and the register file
    task automatic forward_chain();
        int             start;
        int             cycles;
        logic [11:0]    ia;
        logic [11:0]    ib;
        logic [11:0]    ic;
        cpu_pkg::word_t v1;
        cpu_pkg::word_t v2;
        cpu_pkg::word_t v3;
        cpu_pkg::word_t v4;
        start = errors;
        ia = rand_imm();
        ib = rand_imm();
        ic = rand_imm();
        prog.delete();
        prog.push_back(addi(5'd7, 5'd0, ic));
        prog.push_back(addi(5'd1, 5'd0, ia));
        prog.push_back(addi(5'd2, 5'd1, ib));
        prog.push_back(alu_rr(7'd0, `CPU_F3_ADD, 5'd3, 5'd2, 5'd7));
        prog.push_back(alu_rr(`CPU_F7_SUB, `CPU_F3_ADD, 5'd4, 5'd3, 5'd1));
        prog.push_back(alu_rr(7'd0, `CPU_F3_AND, 5'd5, 5'd4, 5'd3));
        prog.push_back(alu_rr(7'd0, `CPU_F3_OR, 5'd6, 5'd5, 5'd2));
        append_halt();
        load_program();
        run_to_halt(cycles);
        check_word("halt cycle", cpu_pkg::word_t'(cycles), 32'd12);  // ecall at 8, no stalls
        v1 = sext(ia);
        v2 = v1 + sext(ib);
        v3 = v2 + sext(ic);
        v4 = v3 - v1;
        check_reg(5'd1, v1);
        check_reg(5'd2, v2);
        check_reg(5'd3, v3);
        check_reg(5'd4, v4);
        check_reg(5'd5, v4 & v3);
        check_reg(5'd6, (v4 & v3) | v2);
        check_reg(5'd7, sext(ic));
        report_test("forward_chain", start);
    endtask

    task automatic load_use();
        int          start;
        int          cycles;
        logic [11:0] ia;
        logic [11:0] ic;
        start = errors;
        ia = rand_imm();
        ic = rand_imm();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, ia));
        prog.push_back(addi(5'd5, 5'd0, ic));
        prog.push_back(addi(5'd2, 5'd0, 12'd32));  // base address
        prog.push_back(store_word(5'd1, 5'd2, 12'd4));
        prog.push_back(load_word(5'd3, 5'd2, 12'd4));
        prog.push_back(alu_rr(7'd0, `CPU_F3_ADD, 5'd4, 5'd3, 5'd5));
        append_halt();
        load_program();
        run_to_halt(cycles);
        check_word("halt cycle", cpu_pkg::word_t'(cycles), 32'd12);  // ecall at 7 plus one bubble
        check_reg(5'd3, sext(ia));
        check_reg(5'd4, sext(ia) + sext(ic));
        report_test("load_use", start);
    endtask

    task automatic branch_paths();
        int start;
        int cycles;
        start = errors;
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd2, 5'd0, 12'd5));
        prog.push_back(addi(5'd3, 5'd0, 12'd7));
        prog.push_back(branch_if(`CPU_F3_BEQ, 5'd1, 5'd2, 13'd12));  // taken to index 6
        prog.push_back(addi(5'd10, 5'd0, 12'd1));
        prog.push_back(addi(5'd11, 5'd0, 12'd1));
        prog.push_back(branch_if(`CPU_F3_BNE, 5'd1, 5'd2, 13'd12));  // not taken
        prog.push_back(addi(5'd12, 5'd0, 12'd2));
        prog.push_back(branch_if(`CPU_F3_BEQ, 5'd1, 5'd3, 13'd8));   // not taken
        prog.push_back(addi(5'd13, 5'd0, 12'd3));
        prog.push_back(branch_if(`CPU_F3_BNE, 5'd1, 5'd3, 13'd12));  // taken to index 13
        prog.push_back(addi(5'd14, 5'd0, 12'd4));
        prog.push_back(addi(5'd15, 5'd0, 12'd4));
        append_halt();
        load_program();
        run_to_halt(cycles);
        // a taken branch costs two cycles and skips two slots so the ecall at 14 lands at 18
        check_word("halt cycle", cpu_pkg::word_t'(cycles), 32'd18);
        check_reg(5'd10, 32'd0);
        check_reg(5'd11, 32'd0);
        check_reg(5'd12, 32'd2);
        check_reg(5'd13, 32'd3);
        check_reg(5'd14, 32'd0);
        check_reg(5'd15, 32'd0);
        report_test("branch_paths", start);
    endtask

    task automatic x0_write();
        int          start;
        int          cycles;
        logic [11:0] imm;
        start = errors;
        imm = rand_imm() | 12'h001;  // never zero
        prog.delete();
        prog.push_back(addi(5'd0, 5'd0, imm));
        prog.push_back(alu_rr(7'd0, `CPU_F3_ADD, 5'd1, 5'd0, 5'd0));
        prog.push_back(addi(5'd2, 5'd0, imm));
        append_halt();
        load_program();
        run_to_halt(cycles);
        check_word("halt cycle", cpu_pkg::word_t'(cycles), 32'd8);
        check_reg(5'd0, 32'd0);
        check_reg(5'd1, 32'd0);
        check_reg(5'd2, sext(imm));
        report_test("x0_write", start);
    endtask

    task automatic ecall_codes();
        int start;
        int cycles;
        start = errors;
        prog.delete();
        prog.push_back(addi(`CPU_HALT_REG, 5'd0, 12'd9));
        prog.push_back({25'd0, `CPU_OP_SYSTEM});
        prog.push_back(addi(5'd5, 5'd0, 12'd77));
        prog.push_back({25'd0, `CPU_OP_SYSTEM});
        prog.push_back(addi(5'd6, 5'd5, 12'd1));
        append_halt();
        load_program();
        run_to_halt(cycles);
        check_word("halt cycle", cpu_pkg::word_t'(cycles), 32'd10);  // only the ecall at 6
        check_reg(5'd5, 32'd77);
        check_reg(5'd6, 32'd78);
        check_reg(`CPU_HALT_REG, `CPU_HALT_CODE);
        report_test("ecall_codes", start);
    endtask

    task automatic reset_rerun();
        int          start;
        int          cycles;
        logic [11:0] ia;
        logic [11:0] ib;
        start = errors;
        ia = rand_imm();
        ib = rand_imm();
        prog.delete();
        prog.push_back(addi(5'd7, 5'd0, ia));
        append_halt();
        load_program();
        run_to_halt(cycles);
        check_reg(5'd7, sext(ia));
        check_halt("is_halted", is_halted, 1'b1);
        @(posedge clk);
        #2;
        tb_reset = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_halt("is_halted", is_halted, 1'b0);
        for (int r = 1; r < 32; r++) begin
            check_reg(r[4:0], 32'd0);  // read while reset is held
        end
        prog.delete();
        prog.push_back(addi(5'd8, 5'd0, ib));
        prog.push_back(alu_rr(7'd0, `CPU_F3_ADD, 5'd9, 5'd8, 5'd8));
        append_halt();
        load_program();
        run_to_halt(cycles);
        check_word("halt cycle", cpu_pkg::word_t'(cycles), 32'd7);
        check_reg(5'd7, 32'd0);
        check_reg(5'd8, sext(ib));
        check_reg(5'd9, sext(ib) + sext(ib));
        report_test("reset_rerun", start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        tb_reset     = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        lcg_state    = LCG_SEED;
        errors       = 0;
        tests_failed = 0;
        wait (por == 1'b0);
        forward_chain();
        load_use();
        branch_paths();
        x0_write();
        ecall_codes();
        reset_rerun();
        $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end
endmodule

/* sim.f */
+incdir+.
cpu_pkg.sv
fwd_if.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
clock_gen.sv
cpu_properties.sv
cpu_tb.sv

/* Makefile */
# build and run the cpu testbench with Verilator
sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module cpu_tb -f sim.f
	./obj_dir/Vcpu_tb | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
